// ==== include/filterCoeffs.svh ====
`ifndef FILTER_COEFFS_SVH
`define FILTER_COEFFS_SVH

// Symmetric lowpass taps in Q4.12
// Index i weights bit i of the control word
localparam logic signed [COEF_WIDTH-1:0] FILTER_COEF [WORD_BITS] = '{
    16'sd700,
    16'sd1200,
    16'sd1800,
    16'sd2400,
    16'sd2900,
    16'sd3100,
    16'sd3100,
    16'sd2900,
    16'sd2400,
    16'sd1800,
    16'sd1200,
    16'sd700
};

`endif

// ==== verilog/fixFormatPkg.sv ====
package fixFormatPkg;

    // Control decisions per downsampled period
    localparam int WORD_BITS = 12;

    localparam int COEF_WIDTH = 16;
    localparam int COEF_FRAC = 12;

    // Accumulator keeps the coefficient fraction
    localparam int ACC_WIDTH = 24;

    localparam int OUT_WIDTH = 14;

    // 0.875 in Q4.12
    localparam logic signed [COEF_WIDTH-1:0] LAMBDA = 16'sd3584;

    `include "filterCoeffs.svh"

endpackage

// ==== verilog/streamPkg.sv ====
package streamPkg;

    // Longest batch the index field can count
    localparam int BATCH_LEN_MAX = 16;
    localparam int BATCH_IDX_WIDTH = $clog2(BATCH_LEN_MAX);

    typedef struct packed {
        logic [fixFormatPkg::WORD_BITS-1:0] bits;
    } sampleWordT;

    // Dot product of one word, flagged on the first word of the stream
    typedef struct packed {
        logic signed [fixFormatPkg::ACC_WIDTH-1:0] value;
        logic                                      batchStart;
    } contribT;

    typedef struct packed {
        logic signed [fixFormatPkg::ACC_WIDTH-1:0] value;
        logic [BATCH_IDX_WIDTH-1:0]                batchIndex;
    } filtSampleT;

    // Code is offset binary
    typedef struct packed {
        logic [fixFormatPkg::OUT_WIDTH-1:0] code;
        logic [BATCH_IDX_WIDTH-1:0]         batchIndex;
    } resultT;

endpackage

// ==== verilog/sampleReceiver.sv ====
`timescale 1ns/1ps

module sampleReceiver (
    input  logic                  clkDS,
    input  logic                  rst,
    input  logic                  inReq,
    input  streamPkg::sampleWordT inWord,
    output logic                  inAck,
    input  logic                  creditOk,
    output logic                  wordValid,
    output streamPkg::sampleWordT word
);

    typedef enum logic [1:0] {
        rxIdle,
        rxAcked,
        rxWaitLow
    } rxStateT;

    rxStateT rxState;
    logic    capture;

    // Only admit a new word while the output side has room
    assign capture = (rxState == rxIdle) && inReq && creditOk;

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            rxState <= rxIdle;
        end else begin
            case (rxState)
                rxIdle: begin
                    if (capture) begin
                        rxState <= rxAcked;
                    end
                end
                rxAcked: begin
                    rxState <= rxWaitLow;
                end
                rxWaitLow: begin
                    if (!inReq) begin
                        rxState <= rxIdle;
                    end
                end
                default: begin
                    rxState <= rxIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clkDS) begin
        if (capture) begin
            word <= inWord;
        end
    end

    // Ack held until req drops
    assign inAck = (rxState != rxIdle);
    assign wordValid = (rxState == rxAcked);

endmodule

// ==== verilog/lutDotProduct.sv ====
`timescale 1ns/1ps

module lutDotProduct #(
    parameter int LUT_SIZE = 4
) (
    input  logic                  clkDS,
    input  logic                  rst,
    input  logic                  wordValid,
    input  streamPkg::sampleWordT word,
    output logic                  contribValid,
    output streamPkg::contribT    contrib
);

    import fixFormatPkg::*;

    localparam int NUM_GROUPS = (WORD_BITS + LUT_SIZE - 1) / LUT_SIZE;
    localparam int PAD_WIDTH = NUM_GROUPS * LUT_SIZE;

    typedef logic signed [ACC_WIDTH-1:0] groupTableT [2**LUT_SIZE];

    // Each bit counts as +coef when set and -coef when clear
    function automatic groupTableT buildTable(int group);
        groupTableT tbl;
        int         bitPos;
        for (int p = 0; p < 2**LUT_SIZE; p++) begin
            tbl[p] = '0;
            for (int b = 0; b < LUT_SIZE; b++) begin
                bitPos = group * LUT_SIZE + b;
                if (bitPos < WORD_BITS) begin
                    if (p[b]) begin
                        tbl[p] = tbl[p] + FILTER_COEF[bitPos];
                    end else begin
                        tbl[p] = tbl[p] - FILTER_COEF[bitPos];
                    end
                end
            end
        end
        return tbl;
    endfunction

    logic [PAD_WIDTH-1:0]        paddedBits;
    logic signed [ACC_WIDTH-1:0] groupVal [NUM_GROUPS];
    logic signed [ACC_WIDTH-1:0] groupSum;
    logic                        stageOneValid;
    logic                        stageOneStart;
    logic                        seenWord;

    // Unused upper pad bits are ignored by the last table
    assign paddedBits = PAD_WIDTH'(word.bits);

    for (genvar g = 0; g < NUM_GROUPS; g++) begin : gGroup
        localparam groupTableT TABLE = buildTable(g);
        always_ff @(posedge clkDS) begin
            if (wordValid) begin
                groupVal[g] <= TABLE[paddedBits[g*LUT_SIZE +: LUT_SIZE]];
            end
        end
    end

    always_comb begin
        groupSum = '0;
        for (int g = 0; g < NUM_GROUPS; g++) begin
            groupSum = groupSum + groupVal[g];
        end
    end

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            stageOneValid <= 1'b0;
            contribValid <= 1'b0;
            seenWord <= 1'b0;
        end else begin
            stageOneValid <= wordValid;
            contribValid <= stageOneValid;
            if (wordValid) begin
                seenWord <= 1'b1;
            end
        end
    end

    always_ff @(posedge clkDS) begin
        if (wordValid) begin
            stageOneStart <= !seenWord;
        end
        if (stageOneValid) begin
            contrib.value <= groupSum;
            contrib.batchStart <= stageOneStart;
        end
    end

endmodule

// ==== verilog/batchRecursion.sv ====
`timescale 1ns/1ps

module batchRecursion #(
    parameter int BATCH_LEN = 15
) (
    input  logic                  clkDS,
    input  logic                  rst,
    input  logic                  contribValid,
    input  streamPkg::contribT    contrib,
    output logic                  filtValid,
    output streamPkg::filtSampleT filt
);

    import fixFormatPkg::*;
    import streamPkg::*;

    if ($clog2(BATCH_LEN) > BATCH_IDX_WIDTH) begin : gLenCheck
        $error("BATCH_LEN does not fit the batch index field");
    end

    localparam logic [BATCH_IDX_WIDTH-1:0] LAST_IDX = BATCH_IDX_WIDTH'(BATCH_LEN - 1);

    logic signed [ACC_WIDTH-1:0]            state;
    logic signed [ACC_WIDTH-1:0]            prevState;
    logic signed [ACC_WIDTH+COEF_WIDTH-1:0] product;
    logic signed [ACC_WIDTH-1:0]            nextState;
    logic [BATCH_IDX_WIDTH-1:0]             batchIdx;
    logic [BATCH_IDX_WIDTH-1:0]             outIdx;

    // First word of a batch sees a zero state
    assign prevState = (batchIdx == '0) ? '0 : state;
    assign product = prevState * LAMBDA;
    assign nextState = contrib.value + ACC_WIDTH'(product >>> COEF_FRAC);

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            state <= '0;
            batchIdx <= '0;
            outIdx <= '0;
            filtValid <= 1'b0;
        end else begin
            filtValid <= contribValid;
            if (contribValid) begin
                state <= nextState;
                outIdx <= batchIdx;
                batchIdx <= (batchIdx == LAST_IDX) ? '0 : batchIdx + 1'b1;
            end
        end
    end

    assign filt.value = state;
    assign filt.batchIndex = outIdx;

endmodule

// ==== verilog/resultSender.sv ====
`timescale 1ns/1ps

module resultSender #(
    parameter int SCALE_SHIFT = 4,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                  clkDS,
    input  logic                  rst,
    input  logic                  filtValid,
    input  streamPkg::filtSampleT filt,
    input  logic                  wordValid,
    output logic                  creditOk,
    output logic                  outReq,
    output streamPkg::resultT     outResult,
    input  logic                  outAck
);

    import fixFormatPkg::*;
    import streamPkg::*;

    localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int CNT_WIDTH = $clog2(FIFO_DEPTH + 1);
    localparam logic signed [ACC_WIDTH-1:0] OUT_MAX = 2**(OUT_WIDTH-1) - 1;
    localparam logic signed [ACC_WIDTH-1:0] OUT_MIN = -(2**(OUT_WIDTH-1));

    typedef enum logic [1:0] {
        txIdle,
        txReq,
        txWaitLow
    } txStateT;

    function automatic logic [PTR_WIDTH-1:0] nextPtr(input logic [PTR_WIDTH-1:0] ptr);
        return (ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    logic signed [ACC_WIDTH-1:0] shifted;
    logic signed [OUT_WIDTH-1:0] saturated;
    resultT                      newEntry;
    resultT                      queueMem [FIFO_DEPTH];
    logic [PTR_WIDTH-1:0]        wrPtr;
    logic [PTR_WIDTH-1:0]        rdPtr;
    logic [CNT_WIDTH-1:0]        qCount;
    logic [CNT_WIDTH-1:0]        outstanding;
    txStateT                     txState;
    logic                        launch;
    logic                        done;

    assign shifted = filt.value >>> SCALE_SHIFT;

    always_comb begin
        if (shifted > OUT_MAX) begin
            saturated = OUT_MAX[OUT_WIDTH-1:0];
        end else if (shifted < OUT_MIN) begin
            saturated = OUT_MIN[OUT_WIDTH-1:0];
        end else begin
            saturated = shifted[OUT_WIDTH-1:0];
        end
    end

    // Offset binary is two's complement with the sign bit flipped
    assign newEntry.code = {~saturated[OUT_WIDTH-1], saturated[OUT_WIDTH-2:0]};
    assign newEntry.batchIndex = filt.batchIndex;

    assign launch = (txState == txIdle) && (qCount != '0);
    assign done = (txState == txReq) && outAck;

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            txState <= txIdle;
            wrPtr <= '0;
            rdPtr <= '0;
            qCount <= '0;
            outstanding <= '0;
        end else begin
            case (txState)
                txIdle:    if (launch) txState <= txReq;
                txReq:     if (outAck) txState <= txWaitLow;
                txWaitLow: if (!outAck) txState <= txIdle;
                default:   txState <= txIdle;
            endcase
            if (filtValid) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (launch) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({filtValid, launch})
                2'b10:   qCount <= qCount + 1'b1;
                2'b01:   qCount <= qCount - 1'b1;
                default: qCount <= qCount;
            endcase
            // Pipeline words count from admission until their result is taken
            case ({wordValid, done})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    always_ff @(posedge clkDS) begin
        if (filtValid) begin
            queueMem[wrPtr] <= newEntry;
        end
        if (launch) begin
            outResult <= queueMem[rdPtr];
        end
    end

    assign creditOk = (outstanding < CNT_WIDTH'(FIFO_DEPTH));
    assign outReq = (txState == txReq);

endmodule

// ==== verilog/batchFilterTop.sv ====
`timescale 1ns/1ps

module batchFilterTop #(
    parameter int BATCH_LEN = 15,
    parameter int LUT_SIZE = 4,
    parameter int FIFO_DEPTH = 8,
    parameter int SCALE_SHIFT = 4
) (
    input  logic                  clkDS,
    input  logic                  rst,
    input  logic                  inReq,
    input  streamPkg::sampleWordT inWord,
    output logic                  inAck,
    output logic                  outReq,
    output streamPkg::resultT     outResult,
    input  logic                  outAck
);

    import streamPkg::*;

    logic       creditOk;
    logic       wordValid;
    sampleWordT word;
    logic       contribValid;
    contribT    contrib;
    logic       filtValid;
    filtSampleT filt;

    sampleReceiver sampleReceiver_i (
        .clkDS(clkDS),
        .rst(rst),
        .inReq(inReq),
        .inWord(inWord),
        .inAck(inAck),
        .creditOk(creditOk),
        .wordValid(wordValid),
        .word(word)
    );

    lutDotProduct #(
        .LUT_SIZE(LUT_SIZE)
    ) lutDotProduct_i (
        .clkDS(clkDS),
        .rst(rst),
        .wordValid(wordValid),
        .word(word),
        .contribValid(contribValid),
        .contrib(contrib)
    );

    batchRecursion #(
        .BATCH_LEN(BATCH_LEN)
    ) batchRecursion_i (
        .clkDS(clkDS),
        .rst(rst),
        .contribValid(contribValid),
        .contrib(contrib),
        .filtValid(filtValid),
        .filt(filt)
    );

    resultSender #(
        .SCALE_SHIFT(SCALE_SHIFT),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) resultSender_i (
        .clkDS(clkDS),
        .rst(rst),
        .filtValid(filtValid),
        .filt(filt),
        .wordValid(wordValid),
        .creditOk(creditOk),
        .outReq(outReq),
        .outResult(outResult),
        .outAck(outAck)
    );

endmodule

// ==== verif/batchFilter_asserts.sv ====
`timescale 1ns/1ps

module batchFilter_asserts (
    input logic              clkDS,
    input logic              rst,
    input logic              inReq,
    input logic              inAck,
    input logic              outReq,
    input streamPkg::resultT outResult,
    input logic              outAck
);

    int unsigned failCount = 0;

    // Sender keeps req up until the consumer answers
    reqHeld: assert property (@(posedge clkDS) disable iff (!rst)
        outReq && !outAck |=> outReq)
    else begin
        $error("outReq dropped before outAck rose");
        failCount++;
    end

    resultStable: assert property (@(posedge clkDS) disable iff (!rst)
        outReq |=> $stable(outResult))
    else begin
        $error("outResult changed during an output handshake");
        failCount++;
    end

    ackNeedsReq: assert property (@(posedge clkDS) disable iff (!rst)
        $rose(inAck) |-> inReq)
    else begin
        $error("inAck rose without inReq");
        failCount++;
    end

    // Both links idle while in reset and right after release
    idleAfterReset: assert property (@(posedge clkDS)
        (!rst || $rose(rst)) |-> (!inAck && !outReq))
    else begin
        $error("inAck or outReq high after reset");
        failCount++;
    end

endmodule

bind batchFilterTop batchFilter_asserts batchFilterAsserts_i (
    .clkDS(clkDS),
    .rst(rst),
    .inReq(inReq),
    .inAck(inAck),
    .outReq(outReq),
    .outResult(outResult),
    .outAck(outAck)
);

// ==== verif/batchFilterTb.sv ====
`timescale 1ns/1ps

module batchFilterTb;

    import fixFormatPkg::*;
    import streamPkg::*;

    localparam int BATCH_LEN = 15;
    localparam int LUT_SIZE = 4;
    localparam int FIFO_DEPTH = 8;
    localparam int SCALE_SHIFT = 4;
    localparam int HOLD_CYCLES = 150;
    // Fixed words, three random batches, stalled burst, two saturation runs
    localparam int TOTAL_WORDS = 8 + 3 * BATCH_LEN + FIFO_DEPTH + 4 + 4 * BATCH_LEN;
    localparam int TIMEOUT_NS = TOTAL_WORDS * 200;
    localparam logic [OUT_WIDTH-1:0] CODE_MAX = '1;
    localparam logic [OUT_WIDTH-1:0] CODE_MIN = '0;

    logic       clkDS;
    logic       rst;
    logic       inReq;
    sampleWordT inWord;
    logic       inAck;
    logic       outReq;
    resultT     outResult;
    logic       outAck;

    resultT expQ [$];
    longint modelState;
    int     modelWords;
    int     acceptedWords;
    int     checks;
    int     errors;
    int     testChecks;
    int     testErrors;
    int     maxCodes;
    int     minCodes;
    int     wraps;
    bit     holdAck;

    batchFilterTop #(
        .BATCH_LEN(BATCH_LEN),
        .LUT_SIZE(LUT_SIZE),
        .FIFO_DEPTH(FIFO_DEPTH),
        .SCALE_SHIFT(SCALE_SHIFT)
    ) batchFilterTop_i (
        .clkDS(clkDS),
        .rst(rst),
        .inReq(inReq),
        .inWord(inWord),
        .inAck(inAck),
        .outReq(outReq),
        .outResult(outResult),
        .outAck(outAck)
    );

    initial begin
        clkDS = 1'b0;
        forever #2 clkDS = ~clkDS;
    end

    // Reference model, one call per word in send order
    task automatic predictResult(input logic [WORD_BITS-1:0] bits, output resultT expected);
        longint contribution;
        longint scaled;
        int     idx;
        contribution = 0;
        for (int b = 0; b < WORD_BITS; b++) begin
            if (bits[b]) begin
                contribution = contribution + FILTER_COEF[b];
            end else begin
                contribution = contribution - FILTER_COEF[b];
            end
        end
        idx = modelWords % BATCH_LEN;
        if (idx == 0) begin
            modelState = contribution;
        end else begin
            modelState = contribution + ((modelState * LAMBDA) >>> COEF_FRAC);
        end
        scaled = modelState >>> SCALE_SHIFT;
        if (scaled > 2**(OUT_WIDTH-1) - 1) begin
            scaled = 2**(OUT_WIDTH-1) - 1;
        end else if (scaled < -(2**(OUT_WIDTH-1))) begin
            scaled = -(2**(OUT_WIDTH-1));
        end
        // Offset binary adds half the code range
        expected.code = OUT_WIDTH'(scaled + 2**(OUT_WIDTH-1));
        expected.batchIndex = BATCH_IDX_WIDTH'(idx);
        modelWords++;
    endtask

    task automatic sendWord(input logic [WORD_BITS-1:0] bits);
        resultT expected;
        predictResult(bits, expected);
        expQ.push_back(expected);
        @(posedge clkDS);
        inWord.bits <= bits;
        inReq <= 1'b1;
        do @(negedge clkDS); while (!inAck);
        acceptedWords++;
        @(posedge clkDS);
        inReq <= 1'b0;
        do @(negedge clkDS); while (inAck);
    endtask

    task automatic checkResult(input resultT got);
        resultT expected;
        checks++;
        assert (expQ.size() > 0) else begin
            errors++;
            $display("Result arrived at %0t with no word outstanding", $time);
        end
        if (expQ.size() > 0) begin
            expected = expQ.pop_front();
            assert (got == expected) else begin
                errors++;
                $display("Mismatch at %0t: code %h index %0d, expected code %h index %0d",
                    $time, got.code, got.batchIndex, expected.code, expected.batchIndex);
            end
        end
        if (got.code == CODE_MAX) maxCodes++;
        if (got.code == CODE_MIN) minCodes++;
        if (got.batchIndex == BATCH_IDX_WIDTH'(BATCH_LEN - 1)) wraps++;
    endtask

    task automatic waitDrained();
        do @(negedge clkDS); while (expQ.size() != 0 || outReq || outAck || inAck);
    endtask

    task automatic finishTest(input string name);
        $display("%s done: %0d checks, %0d errors", name, checks - testChecks,
            errors - testErrors);
        testChecks = checks;
        testErrors = errors;
    endtask

    // Consumer side of the output link, random ack delay
    initial begin : consumer
        resultT got;
        outAck = 1'b0;
        forever begin
            @(negedge clkDS);
            if (outReq && !holdAck) begin
                got = outResult;
                checkResult(got);
                repeat ($urandom % 4) @(posedge clkDS);
                @(posedge clkDS);
                outAck <= 1'b1;
                do @(negedge clkDS); while (outReq);
                @(posedge clkDS);
                outAck <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout: results still missing after %0d ns", TIMEOUT_NS);
        $display("Test failed");
        $finish;
    end

    initial begin : main
        void'($urandom(32'h98fe_60ca));
        rst = 1'b0;
        inReq = 1'b0;
        inWord = '0;
        holdAck = 1'b0;
        modelState = 0;
        modelWords = 0;
        acceptedWords = 0;
        checks = 0;
        errors = 0;
        testChecks = 0;
        testErrors = 0;
        maxCodes = 0;
        minCodes = 0;
        wraps = 0;
        repeat (3) @(posedge clkDS);
        rst <= 1'b1;

        repeat (10) begin
            @(negedge clkDS);
            checks++;
            assert (!outReq && !inAck) else begin
                errors++;
                $display("Handshake outputs active at %0t with no word offered", $time);
            end
        end
        finishTest("reset");

        repeat (4) sendWord('1);
        repeat (4) sendWord('0);
        waitDrained();
        finishTest("fixed words");

        wraps = 0;
        repeat (3 * BATCH_LEN) sendWord(WORD_BITS'($urandom));
        waitDrained();
        checks++;
        assert (wraps >= 2) else begin
            errors++;
            $display("Batch index did not wrap over three batches");
        end
        finishTest("batch restart");

        holdAck = 1'b1;
        acceptedWords = 0;
        fork
            repeat (FIFO_DEPTH + 4) sendWord(WORD_BITS'($urandom));
            begin
                repeat (HOLD_CYCLES) @(posedge clkDS);
                checks++;
                assert (acceptedWords == FIFO_DEPTH) else begin
                    errors++;
                    $display("Input accepted %0d words during the stall, limit is %0d",
                        acceptedWords, FIFO_DEPTH);
                end
                holdAck = 1'b0;
            end
        join
        waitDrained();
        finishTest("back-pressure");

        maxCodes = 0;
        minCodes = 0;
        repeat (2 * BATCH_LEN) sendWord('1);
        repeat (2 * BATCH_LEN) sendWord('0);
        waitDrained();
        checks++;
        assert (maxCodes > 0 && minCodes > 0) else begin
            errors++;
            $display("Output codes did not reach both ends of the range");
        end
        finishTest("saturation");

        errors = errors + int'(batchFilterTop_i.batchFilterAsserts_i.failCount);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+include
verilog/fixFormatPkg.sv
verilog/streamPkg.sv
verilog/sampleReceiver.sv
verilog/lutDotProduct.sv
verilog/batchRecursion.sv
verilog/resultSender.sv
verilog/batchFilterTop.sv
verif/batchFilter_asserts.sv
verif/batchFilterTb.sv

// ==== run.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module batchFilterTb -f src.f -o batchFilterSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/batchFilterSim +verilator+error+limit+1000)
simStatus=$?
printf '%s\n' "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if printf '%s\n' "$simOut" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
